/* design/dma_tcdm_pkg.sv */
// DMA TCDM access package
// Shared widths, depths and the TCDM data word view

package dma_tcdm_pkg;

   //**********************************************************
   // Transfer and address widths
   //**********************************************************

   // Transfer ID carried with every beat
   localparam int TRANS_SID_WIDTH = 2;

   // Byte address of a beat covering 64 words of 4 bytes
   localparam int TCDM_ADD_WIDTH = 8;

   // Number of words in the single bank
   localparam int TCDM_WORDS = 64;

   // Word index width inside the bank
   localparam int TCDM_IDX_WIDTH = $clog2(TCDM_WORDS);

   //**********************************************************
   // Receive buffer sizing
   //**********************************************************

   localparam int RX_FIFO_DEPTH = 4;

   // Pointer and occupancy widths of the receive buffer
   localparam int RX_PTR_WIDTH = $clog2(RX_FIFO_DEPTH);
   localparam int RX_CNT_WIDTH = $clog2(RX_FIFO_DEPTH + 1);

   //**********************************************************
   // TCDM data word
   //**********************************************************

   // Same 32 bits seen whole or as byte lanes
   // Lane 0 is the least significant byte
   typedef union packed {
      logic [31:0]     word;
      logic [3:0][7:0] lane;
   } tcdm_word_u;

endpackage

/* design/rx_data_fifo.sv */
// Receive data buffer
// Holds write words and their byte strobes until the receive engine pops them

`timescale 1ns/1ps

module rx_data_fifo
   import dma_tcdm_pkg::*;
(
   input  logic        clk_i,
   input  logic        arst_n_i,
   input  logic        push_i,
   input  logic [31:0] dat_i,
   input  logic [3:0]  strb_i,
   input  logic        pop_i,
   output logic        full_o,
   output logic        not_empty_o,
   output logic [31:0] head_dat_o,
   output logic [3:0]  head_strb_o
);

   // Entry storage
   logic [31:0]             dat_q  [RX_FIFO_DEPTH];
   logic [3:0]              strb_q [RX_FIFO_DEPTH];
   logic [RX_PTR_WIDTH-1:0] wr_ptr_q;
   logic [RX_PTR_WIDTH-1:0] rd_ptr_q;
   logic [RX_CNT_WIDTH-1:0] cnt_q;
   logic                    push_en;
   logic                    pop_en;

   assign full_o      = (cnt_q == RX_CNT_WIDTH'(RX_FIFO_DEPTH));
   assign not_empty_o = (cnt_q != '0);

   // Ignore a push when full and a pop when empty
   assign push_en = push_i & ~full_o;
   assign pop_en  = pop_i & not_empty_o;

   // Head entry is visible without delay
   assign head_dat_o  = dat_q[rd_ptr_q];
   assign head_strb_o = strb_q[rd_ptr_q];

   always_ff @(posedge clk_i)
   begin
      if (push_en)
      begin
         dat_q[wr_ptr_q]  <= dat_i;
         strb_q[wr_ptr_q] <= strb_i;
      end
   end

   // Pointers wrap at the last entry
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         cnt_q    <= '0;
      end
      else
      begin
         if (push_en)
            wr_ptr_q <= (wr_ptr_q == RX_PTR_WIDTH'(RX_FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         if (pop_en)
            rd_ptr_q <= (rd_ptr_q == RX_PTR_WIDTH'(RX_FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         // Occupancy moves only when one side acts alone
         if (push_en && !pop_en)
            cnt_q <= cnt_q + 1'b1;
         else if (pop_en && !push_en)
            cnt_q <= cnt_q - 1'b1;
      end
   end

endmodule

/* design/tcdm_rx_if.sv */
// TCDM receive engine
// Pairs write beats with buffered data words and issues TCDM writes

`timescale 1ns/1ps

module tcdm_rx_if
   import dma_tcdm_pkg::*;
(
   // Write beat from the command side
   input  logic                       beat_eop_i,
   input  logic [TRANS_SID_WIDTH-1:0] beat_sid_i,
   input  logic [TCDM_ADD_WIDTH-1:0]  beat_add_i,
   input  logic                       beat_we_ni,
   input  logic                       beat_req_i,
   output logic                       beat_gnt_o,

   // End of transfer report
   output logic                       synch_req_o,
   output logic [TRANS_SID_WIDTH-1:0] synch_sid_o,

   // Receive buffer head
   input  logic [31:0]                rx_data_dat_i,
   input  logic [3:0]                 rx_data_strb_i,
   output logic                       rx_data_req_o,
   input  logic                       rx_data_gnt_i,

   // TCDM initiator side
   output logic                       tcdm_req_o,
   output logic [TCDM_ADD_WIDTH-1:0]  tcdm_add_o,
   output logic                       tcdm_we_o,
   output logic [31:0]                tcdm_wdata_o,
   output logic [3:0]                 tcdm_be_o,
   input  logic                       tcdm_gnt_i
);

   //**********************************************************
   // Request channel
   //**********************************************************

   always_comb
   begin
      tcdm_req_o    = 1'b0;
      beat_gnt_o    = 1'b0;
      rx_data_req_o = 1'b0;
      synch_req_o   = 1'b0;
      synch_sid_o   = '0;
      // Write beat with a data word waiting in the buffer
      if (beat_req_i && !beat_we_ni && rx_data_gnt_i)
      begin
         tcdm_req_o = 1'b1;
         // Accept beat and pop data in the grant cycle
         if (tcdm_gnt_i)
         begin
            beat_gnt_o    = 1'b1;
            rx_data_req_o = 1'b1;
            synch_req_o   = beat_eop_i;
            synch_sid_o   = beat_sid_i;
         end
      end
   end

   // Address, data and strobes go straight to the TCDM
   assign tcdm_add_o   = beat_add_i;
   assign tcdm_we_o    = beat_we_ni;
   assign tcdm_wdata_o = rx_data_dat_i;
   assign tcdm_be_o    = rx_data_strb_i;

endmodule

/* design/tcdm_tx_if.sv */
// TCDM transmit engine
// Turns read beats into TCDM reads and hands the returned words to the consumer

`timescale 1ns/1ps

module tcdm_tx_if
   import dma_tcdm_pkg::*;
(
   input  logic                       clk_i,
   input  logic                       arst_n_i,

   // Read beat from the command side
   input  logic                       beat_eop_i,
   input  logic [TRANS_SID_WIDTH-1:0] beat_sid_i,
   input  logic [TCDM_ADD_WIDTH-1:0]  beat_add_i,
   input  logic                       beat_req_i,
   output logic                       beat_gnt_o,

   // Consumer ready level
   input  logic                       tx_ready_i,

   // TCDM initiator side
   output logic                       tcdm_req_o,
   output logic [TCDM_ADD_WIDTH-1:0]  tcdm_add_o,
   output logic                       tcdm_we_o,
   input  logic                       tcdm_gnt_i,
   input  logic [31:0]                tcdm_r_rdata_i,
   input  logic                       tcdm_r_valid_i,

   // End of transfer report
   output logic                       synch_req_o,
   output logic [TRANS_SID_WIDTH-1:0] synch_sid_o,

   // Returned data
   output logic                       tx_data_valid_o,
   output logic [31:0]                tx_data_o
);

   // Tag of the read in flight
   logic                       eop_q;
   logic [TRANS_SID_WIDTH-1:0] sid_q;

   //**********************************************************
   // Request channel
   //**********************************************************

   // Read only while the consumer can take the word
   assign tcdm_req_o = beat_req_i & tx_ready_i;
   assign tcdm_add_o = beat_add_i;
   // High we_n marks a read
   assign tcdm_we_o  = 1'b1;
   assign beat_gnt_o = tcdm_req_o & tcdm_gnt_i;

   // One read per cycle, so the tag is overwritten each grant
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
         eop_q <= 1'b0;
      else if (beat_gnt_o)
         eop_q <= beat_eop_i;
   end

   always_ff @(posedge clk_i)
   begin
      if (beat_gnt_o)
         sid_q <= beat_sid_i;
   end

   //**********************************************************
   // Response channel
   //**********************************************************

   // Response arrives one cycle after the grant
   assign tx_data_valid_o = tcdm_r_valid_i;
   assign tx_data_o       = tcdm_r_rdata_i;

   // Report the transfer with its last word
   assign synch_req_o = tcdm_r_valid_i & eop_q;
   assign synch_sid_o = sid_q;

endmodule

/* design/tcdm_arbiter.sv */
// TCDM port arbiter
// Round-robin sharing of one TCDM port between two engines, with read routing

`timescale 1ns/1ps

module tcdm_arbiter
   import dma_tcdm_pkg::*;
(
   input  logic                      clk_i,
   input  logic                      arst_n_i,

   // Peer 0 is the receive engine
   input  logic                      p0_req_i,
   input  logic [TCDM_ADD_WIDTH-1:0] p0_add_i,
   input  logic                      p0_we_i,
   input  logic [31:0]               p0_wdata_i,
   input  logic [3:0]                p0_be_i,
   output logic                      p0_gnt_o,

   // Peer 1 is the transmit engine
   input  logic                      p1_req_i,
   input  logic [TCDM_ADD_WIDTH-1:0] p1_add_i,
   input  logic                      p1_we_i,
   input  logic [31:0]               p1_wdata_i,
   input  logic [3:0]                p1_be_i,
   output logic                      p1_gnt_o,
   output logic [31:0]               p1_r_rdata_o,
   output logic                      p1_r_valid_o,

   // Bank side
   output logic                      mem_req_o,
   output logic [TCDM_ADD_WIDTH-1:0] mem_add_o,
   output logic                      mem_we_o,
   output logic [31:0]               mem_wdata_o,
   output logic [3:0]                mem_be_o,
   input  logic [31:0]               mem_r_rdata_i,
   input  logic                      mem_r_valid_i
);

   // Peer 0 won the last arbitration
   logic last_p0_q;
   // Read issued last cycle belongs to peer 1
   logic rd_p1_q;
   logic sel_p1;

   // Peer 1 wins alone or on a tie after peer 0
   assign sel_p1 = p1_req_i & (~p0_req_i | last_p0_q);

   // The bank grants every request
   assign p0_gnt_o = p0_req_i & ~sel_p1;
   assign p1_gnt_o = sel_p1;

   // Winner fields to the bank
   assign mem_req_o   = p0_req_i | p1_req_i;
   assign mem_add_o   = sel_p1 ? p1_add_i   : p0_add_i;
   assign mem_we_o    = sel_p1 ? p1_we_i    : p0_we_i;
   assign mem_wdata_o = sel_p1 ? p1_wdata_i : p0_wdata_i;
   assign mem_be_o    = sel_p1 ? p1_be_i    : p0_be_i;

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         last_p0_q <= 1'b0;
         rd_p1_q   <= 1'b0;
      end
      else
      begin
         if (p0_gnt_o)
            last_p0_q <= 1'b1;
         else if (p1_gnt_o)
            last_p0_q <= 1'b0;
         // Write responses are dropped
         rd_p1_q <= p1_gnt_o & p1_we_i;
      end
   end

   // Responses go back to peer 1 only
   assign p1_r_valid_o = mem_r_valid_i & rd_p1_q;
   assign p1_r_rdata_o = mem_r_rdata_i;

endmodule

/* design/tcdm_bank.sv */
// Single-port TCDM bank model
// Byte-lane writes and one-cycle reads, grants every request

`timescale 1ns/1ps

module tcdm_bank
   import dma_tcdm_pkg::*;
(
   input  logic                      clk_i,
   input  logic                      arst_n_i,
   input  logic                      req_i,
   input  logic [TCDM_ADD_WIDTH-1:0] add_i,
   input  logic                      we_i,
   input  logic [31:0]               wdata_i,
   input  logic [3:0]                be_i,
   output logic                      gnt_o,
   output logic [31:0]               r_rdata_o,
   output logic                      r_valid_o
);

   tcdm_word_u                mem_q [TCDM_WORDS];
   tcdm_word_u                wdata;
   tcdm_word_u                rdata_q;
   logic [TCDM_IDX_WIDTH-1:0] idx;
   logic                      r_valid_q;

   // Byte address to word index
   assign idx   = add_i[TCDM_IDX_WIDTH+1:2];
   assign wdata = wdata_i;
   assign gnt_o = req_i;

   // Low we marks a write, high a read
   always_ff @(posedge clk_i)
   begin
      if (req_i && !we_i)
      begin
         for (int b = 0; b < 4; b++)
         begin
            if (be_i[b])
               mem_q[idx].lane[b] <= wdata.lane[b];
         end
      end
      if (req_i && we_i)
         rdata_q <= mem_q[idx];
   end

   // Response one cycle after each grant
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
         r_valid_q <= 1'b0;
      else
         r_valid_q <= req_i;
   end

   assign r_valid_o = r_valid_q;
   assign r_rdata_o = rdata_q.word;

endmodule

/* design/dma_tcdm_top.sv */
// DMA TCDM access top
// Receive buffer, both beat engines, arbiter and bank on one TCDM port

`timescale 1ns/1ps

module dma_tcdm_top
   import dma_tcdm_pkg::*;
(
   input  logic                       clk_i,
   input  logic                       arst_n_i,

   // Receive data in
   input  logic                       rx_push_i,
   input  logic [31:0]                rx_dat_i,
   input  logic [3:0]                 rx_strb_i,
   output logic                       rx_full_o,

   // Write beats
   input  logic                       rx_beat_req_i,
   input  logic                       rx_beat_eop_i,
   input  logic [TRANS_SID_WIDTH-1:0] rx_beat_sid_i,
   input  logic [TCDM_ADD_WIDTH-1:0]  rx_beat_add_i,
   output logic                       rx_beat_gnt_o,
   output logic                       rx_synch_req_o,
   output logic [TRANS_SID_WIDTH-1:0] rx_synch_sid_o,

   // Read beats
   input  logic                       tx_beat_req_i,
   input  logic                       tx_beat_eop_i,
   input  logic [TRANS_SID_WIDTH-1:0] tx_beat_sid_i,
   input  logic [TCDM_ADD_WIDTH-1:0]  tx_beat_add_i,
   input  logic                       tx_ready_i,
   output logic                       tx_beat_gnt_o,
   output logic                       tx_data_valid_o,
   output logic [31:0]                tx_data_o,
   output logic                       tx_synch_req_o,
   output logic [TRANS_SID_WIDTH-1:0] tx_synch_sid_o
);

   // Buffer to receive engine
   logic                      fifo_not_empty;
   logic                      fifo_pop;
   logic [31:0]               fifo_dat;
   logic [3:0]                fifo_strb;

   // Receive engine to arbiter
   logic                      rx_req;
   logic                      rx_gnt;
   logic [TCDM_ADD_WIDTH-1:0] rx_add;
   logic                      rx_we;
   logic [31:0]               rx_wdata;
   logic [3:0]                rx_be;

   // Transmit engine to arbiter
   logic                      tx_req;
   logic                      tx_gnt;
   logic [TCDM_ADD_WIDTH-1:0] tx_add;
   logic                      tx_we;
   logic [31:0]               tx_rdata;
   logic                      tx_rvalid;

   // Arbiter to bank
   logic                      mem_req;
   logic [TCDM_ADD_WIDTH-1:0] mem_add;
   logic                      mem_we;
   logic [31:0]               mem_wdata;
   logic [3:0]                mem_be;
   logic [31:0]               mem_rdata;
   logic                      mem_rvalid;

   rx_data_fifo i_rx_data_fifo (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .push_i      (rx_push_i),
      .dat_i       (rx_dat_i),
      .strb_i      (rx_strb_i),
      .pop_i       (fifo_pop),
      .full_o      (rx_full_o),
      .not_empty_o (fifo_not_empty),
      .head_dat_o  (fifo_dat),
      .head_strb_o (fifo_strb)
   );

   // Receive port carries write beats only
   tcdm_rx_if i_tcdm_rx_if (
      .beat_eop_i     (rx_beat_eop_i),
      .beat_sid_i     (rx_beat_sid_i),
      .beat_add_i     (rx_beat_add_i),
      .beat_we_ni     (1'b0),
      .beat_req_i     (rx_beat_req_i),
      .beat_gnt_o     (rx_beat_gnt_o),
      .synch_req_o    (rx_synch_req_o),
      .synch_sid_o    (rx_synch_sid_o),
      .rx_data_dat_i  (fifo_dat),
      .rx_data_strb_i (fifo_strb),
      .rx_data_req_o  (fifo_pop),
      .rx_data_gnt_i  (fifo_not_empty),
      .tcdm_req_o     (rx_req),
      .tcdm_add_o     (rx_add),
      .tcdm_we_o      (rx_we),
      .tcdm_wdata_o   (rx_wdata),
      .tcdm_be_o      (rx_be),
      .tcdm_gnt_i     (rx_gnt)
   );

   tcdm_tx_if i_tcdm_tx_if (
      .clk_i           (clk_i),
      .arst_n_i        (arst_n_i),
      .beat_eop_i      (tx_beat_eop_i),
      .beat_sid_i      (tx_beat_sid_i),
      .beat_add_i      (tx_beat_add_i),
      .beat_req_i      (tx_beat_req_i),
      .beat_gnt_o      (tx_beat_gnt_o),
      .tx_ready_i      (tx_ready_i),
      .tcdm_req_o      (tx_req),
      .tcdm_add_o      (tx_add),
      .tcdm_we_o       (tx_we),
      .tcdm_gnt_i      (tx_gnt),
      .tcdm_r_rdata_i  (tx_rdata),
      .tcdm_r_valid_i  (tx_rvalid),
      .synch_req_o     (tx_synch_req_o),
      .synch_sid_o     (tx_synch_sid_o),
      .tx_data_valid_o (tx_data_valid_o),
      .tx_data_o       (tx_data_o)
   );

   // Reads carry no write data or strobes
   tcdm_arbiter i_tcdm_arbiter (
      .clk_i         (clk_i),
      .arst_n_i      (arst_n_i),
      .p0_req_i      (rx_req),
      .p0_add_i      (rx_add),
      .p0_we_i       (rx_we),
      .p0_wdata_i    (rx_wdata),
      .p0_be_i       (rx_be),
      .p0_gnt_o      (rx_gnt),
      .p1_req_i      (tx_req),
      .p1_add_i      (tx_add),
      .p1_we_i       (tx_we),
      .p1_wdata_i    (32'd0),
      .p1_be_i       (4'd0),
      .p1_gnt_o      (tx_gnt),
      .p1_r_rdata_o  (tx_rdata),
      .p1_r_valid_o  (tx_rvalid),
      .mem_req_o     (mem_req),
      .mem_add_o     (mem_add),
      .mem_we_o      (mem_we),
      .mem_wdata_o   (mem_wdata),
      .mem_be_o      (mem_be),
      .mem_r_rdata_i (mem_rdata),
      .mem_r_valid_i (mem_rvalid)
   );

   // Bank grants every request so the arbiter grants on its behalf
   tcdm_bank i_tcdm_bank (
      .clk_i     (clk_i),
      .arst_n_i  (arst_n_i),
      .req_i     (mem_req),
      .add_i     (mem_add),
      .we_i      (mem_we),
      .wdata_i   (mem_wdata),
      .be_i      (mem_be),
      .gnt_o     (),
      .r_rdata_o (mem_rdata),
      .r_valid_o (mem_rvalid)
   );

endmodule

/* bench/tb_dma_tcdm_top.sv */
// DMA TCDM access testbench
// Directed tests against a byte-lane memory model and a round-robin grant model

`timescale 1ns/1ps

module tb_dma_tcdm_top
   import dma_tcdm_pkg::*;
();

   // Limit well above the length of all tests
   localparam int          TIMEOUT_CYCLES = 2000;
   localparam logic [31:0] LFSR_TAPS      = 32'h8020_0003;

   logic                       clk_i;
   logic                       arst_n_i;
   logic                       rx_push_i;
   logic [31:0]                rx_dat_i;
   logic [3:0]                 rx_strb_i;
   logic                       rx_full_o;
   logic                       rx_beat_req_i;
   logic                       rx_beat_eop_i;
   logic [TRANS_SID_WIDTH-1:0] rx_beat_sid_i;
   logic [TCDM_ADD_WIDTH-1:0]  rx_beat_add_i;
   logic                       rx_beat_gnt_o;
   logic                       rx_synch_req_o;
   logic [TRANS_SID_WIDTH-1:0] rx_synch_sid_o;
   logic                       tx_beat_req_i;
   logic                       tx_beat_eop_i;
   logic [TRANS_SID_WIDTH-1:0] tx_beat_sid_i;
   logic [TCDM_ADD_WIDTH-1:0]  tx_beat_add_i;
   logic                       tx_ready_i;
   logic                       tx_beat_gnt_o;
   logic                       tx_data_valid_o;
   logic [31:0]                tx_data_o;
   logic                       tx_synch_req_o;
   logic [TRANS_SID_WIDTH-1:0] tx_synch_sid_o;

   // Reference state
   tcdm_word_u                 model_mem [TCDM_WORDS];
   logic [31:0]                push_dat_q [$];
   logic [3:0]                 push_strb_q [$];
   logic                       last_rx;
   logic                       rd_pend;
   tcdm_word_u                 rd_exp;
   logic                       rd_eop;
   logic [TRANS_SID_WIDTH-1:0] rd_sid;
   int                         rx_synch_cnt;
   int                         tx_synch_cnt;
   int                         cycle_cnt = 0;
   logic [31:0]                lfsr_q;

   dma_tcdm_top DUT (.*);

   initial
   begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   always @(posedge clk_i)
   begin
      cycle_cnt++;
      if (cycle_cnt >= TIMEOUT_CYCLES)
      begin
         $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
         end_with_failure();
      end
   end

   //**********************************************************
   // Random data and compare tasks
   //**********************************************************

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      lfsr_next = s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
   endfunction

   // One LFSR step per bit taken
   task automatic rand_word(output logic [31:0] w);
      for (int i = 0; i < 32; i++)
      begin
         w[i]   = lfsr_q[0];
         lfsr_q = lfsr_next(lfsr_q);
      end
   endtask

   task end_with_failure();
      $display("Result: FAILED");
      $fatal(1, "simulation stopped at first error");
   endtask

   task check_word(input string sig, input tcdm_word_u exp, input tcdm_word_u act);
      if (act.word !== exp.word)
      begin
         $display("FAILED at %0t: %s expected %08h actual %08h", $time, sig, exp.word, act.word);
         end_with_failure();
      end
   endtask

   task check_sid(input string sig, input logic [TRANS_SID_WIDTH-1:0] exp,
                  input logic [TRANS_SID_WIDTH-1:0] act);
      if (act !== exp)
      begin
         $display("FAILED at %0t: %s expected %0d actual %0d", $time, sig, exp, act);
         end_with_failure();
      end
   endtask

   task check_bit(input string sig, input logic exp, input logic act);
      if (act !== exp)
      begin
         $display("FAILED at %0t: %s expected %b actual %b", $time, sig, exp, act);
         end_with_failure();
      end
   endtask

   //**********************************************************
   // Cycle driver and reference model
   //**********************************************************

   // Pulses and beat requests drop at each falling edge unless driven again
   task start_cycle();
      @(negedge clk_i);
      rx_push_i     = 1'b0;
      rx_beat_req_i = 1'b0;
      tx_beat_req_i = 1'b0;
   endtask

   // Checks every output of the cycle and then steps the model
   task automatic tick();
      tcdm_word_u wd;
      logic [3:0] ws;
      logic       rx_wants;
      logic       tx_wants;
      logic       exp_rx_gnt;
      logic       exp_tx_gnt;
      #1;
      // Round robin with the receive side first after reset
      rx_wants   = rx_beat_req_i && (push_dat_q.size() != 0);
      tx_wants   = tx_beat_req_i && tx_ready_i;
      exp_tx_gnt = tx_wants && (!rx_wants || last_rx);
      exp_rx_gnt = rx_wants && !exp_tx_gnt;
      if (rx_beat_gnt_o && tx_beat_gnt_o)
      begin
         $display("Both engines were granted in the same cycle at %0t", $time);
         end_with_failure();
      end
      check_bit("rx_full_o", push_dat_q.size() == RX_FIFO_DEPTH, rx_full_o);
      check_bit("rx_beat_gnt_o", exp_rx_gnt, rx_beat_gnt_o);
      check_bit("tx_beat_gnt_o", exp_tx_gnt, tx_beat_gnt_o);
      if (exp_rx_gnt)
         last_rx = 1'b1;
      else if (exp_tx_gnt)
         last_rx = 1'b0;
      // Pulses seen on the DUT outputs
      if (rx_synch_req_o)
         rx_synch_cnt++;
      if (tx_synch_req_o)
         tx_synch_cnt++;
      // Read data one cycle after its grant
      check_bit("tx_data_valid_o", rd_pend, tx_data_valid_o);
      check_bit("tx_synch_req_o", rd_pend && rd_eop, tx_synch_req_o);
      if (rd_pend)
      begin
         check_word("tx_data_o", rd_exp, tx_data_o);
         if (rd_eop)
            check_sid("tx_synch_sid_o", rd_sid, tx_synch_sid_o);
      end
      // Write merges the head word lane by lane
      check_bit("rx_synch_req_o", exp_rx_gnt && rx_beat_eop_i, rx_synch_req_o);
      if (exp_rx_gnt)
      begin
         wd = push_dat_q.pop_front();
         ws = push_strb_q.pop_front();
         for (int b = 0; b < 4; b++)
         begin
            if (ws[b])
               model_mem[rx_beat_add_i[TCDM_IDX_WIDTH+1:2]].lane[b] = wd.lane[b];
         end
         if (rx_beat_eop_i)
            check_sid("rx_synch_sid_o", rx_beat_sid_i, rx_synch_sid_o);
      end
      rd_pend = exp_tx_gnt;
      if (exp_tx_gnt)
      begin
         rd_exp = model_mem[tx_beat_add_i[TCDM_IDX_WIDTH+1:2]];
         rd_eop = tx_beat_eop_i;
         rd_sid = tx_beat_sid_i;
      end
      if (rx_push_i && push_dat_q.size() < RX_FIFO_DEPTH)
      begin
         push_dat_q.push_back(rx_dat_i);
         push_strb_q.push_back(rx_strb_i);
      end
   endtask

   task idle(input int n);
      repeat (n)
      begin
         start_cycle();
         tick();
      end
   endtask

   task push_word(input logic [31:0] dat, input logic [3:0] strb);
      start_cycle();
      rx_push_i = 1'b1;
      rx_dat_i  = dat;
      rx_strb_i = strb;
      tick();
   endtask

   task set_rx_beat(input logic [TCDM_ADD_WIDTH-1:0] add, input logic eop,
                    input logic [TRANS_SID_WIDTH-1:0] sid);
      rx_beat_req_i = 1'b1;
      rx_beat_add_i = add;
      rx_beat_eop_i = eop;
      rx_beat_sid_i = sid;
   endtask

   task set_tx_beat(input logic [TCDM_ADD_WIDTH-1:0] add, input logic eop,
                    input logic [TRANS_SID_WIDTH-1:0] sid);
      tx_beat_req_i = 1'b1;
      tx_beat_add_i = add;
      tx_beat_eop_i = eop;
      tx_beat_sid_i = sid;
   endtask

   // Beat held until granted
   task write_beat(input logic [TCDM_ADD_WIDTH-1:0] add, input logic eop,
                   input logic [TRANS_SID_WIDTH-1:0] sid);
      do
      begin
         start_cycle();
         set_rx_beat(add, eop, sid);
         tick();
      end
      while (!rx_beat_gnt_o);
   endtask

   task read_beat(input logic [TCDM_ADD_WIDTH-1:0] add, input logic eop,
                  input logic [TRANS_SID_WIDTH-1:0] sid);
      do
      begin
         start_cycle();
         set_tx_beat(add, eop, sid);
         tick();
      end
      while (!tx_beat_gnt_o);
   endtask

   //**********************************************************
   // Directed tests
   //**********************************************************

   task automatic test_full_word();
      logic [31:0] w;
      for (int i = 0; i < 4; i++)
      begin
         rand_word(w);
         push_word(w, 4'hf);
      end
      for (int i = 0; i < 4; i++)
         write_beat(TCDM_ADD_WIDTH'(i * 4), 1'b0, 2'd0);
      for (int i = 0; i < 4; i++)
         read_beat(TCDM_ADD_WIDTH'(i * 4), 1'b0, 2'd0);
      idle(2);
   endtask

   // Old lanes survive where the second strobe is clear
   task automatic test_strobe_merge();
      logic [31:0] w;
      rand_word(w);
      push_word(w, 4'hf);
      write_beat(8'h40, 1'b0, 2'd0);
      rand_word(w);
      push_word(w, 4'b0101);
      write_beat(8'h40, 1'b0, 2'd0);
      read_beat(8'h40, 1'b0, 2'd0);
      idle(2);
   endtask

   task automatic test_synch();
      logic [31:0] w;
      for (int i = 0; i < 3; i++)
      begin
         rand_word(w);
         push_word(w, 4'hf);
      end
      rx_synch_cnt = 0;
      tx_synch_cnt = 0;
      for (int i = 0; i < 3; i++)
         write_beat(TCDM_ADD_WIDTH'(8'h60 + i * 4), i == 2, 2'd2);
      for (int i = 0; i < 3; i++)
         read_beat(TCDM_ADD_WIDTH'(8'h60 + i * 4), i == 2, 2'd1);
      idle(2);
      if (rx_synch_cnt != 1 || tx_synch_cnt != 1)
      begin
         $display("Expected one sync pulse per engine, saw rx %0d and tx %0d",
                  rx_synch_cnt, tx_synch_cnt);
         end_with_failure();
      end
   endtask

   // Both engines held high together so the grant model sees alternation
   task automatic test_shared_port();
      logic [31:0] w;
      int          rx_left;
      int          tx_left;
      for (int i = 0; i < 4; i++)
      begin
         rand_word(w);
         push_word(w, 4'hf);
      end
      rx_left = 4;
      tx_left = 4;
      while (rx_left > 0 || tx_left > 0)
      begin
         start_cycle();
         if (rx_left > 0)
            set_rx_beat(TCDM_ADD_WIDTH'(8'h80 + (4 - rx_left) * 4), rx_left == 1, 2'd3);
         if (tx_left > 0)
            set_tx_beat(TCDM_ADD_WIDTH'((4 - tx_left) * 4), tx_left == 1, 2'd0);
         tick();
         if (rx_beat_gnt_o)
            rx_left--;
         if (tx_beat_gnt_o)
            tx_left--;
      end
      for (int i = 0; i < 4; i++)
         read_beat(TCDM_ADD_WIDTH'(8'h80 + i * 4), 1'b0, 2'd0);
      idle(2);
   endtask

   task automatic test_back_pressure();
      logic [31:0] w;
      // Empty buffer holds the write beat
      repeat (3)
      begin
         start_cycle();
         set_rx_beat(8'hc0, 1'b1, 2'd1);
         tick();
         check_bit("rx_beat_gnt_o", 1'b0, rx_beat_gnt_o);
      end
      rand_word(w);
      start_cycle();
      set_rx_beat(8'hc0, 1'b1, 2'd1);
      rx_push_i = 1'b1;
      rx_dat_i  = w;
      rx_strb_i = 4'hf;
      tick();
      write_beat(8'hc0, 1'b1, 2'd1);
      // Consumer not ready holds the read beat
      repeat (3)
      begin
         start_cycle();
         tx_ready_i = 1'b0;
         set_tx_beat(8'hc0, 1'b1, 2'd1);
         tick();
         check_bit("tx_beat_gnt_o", 1'b0, tx_beat_gnt_o);
      end
      start_cycle();
      tx_ready_i = 1'b1;
      set_tx_beat(8'hc0, 1'b1, 2'd1);
      tick();
      check_bit("tx_beat_gnt_o", 1'b1, tx_beat_gnt_o);
      // Four pushes with no pops fill the buffer
      for (int i = 0; i < 4; i++)
      begin
         rand_word(w);
         push_word(w, 4'hf);
      end
      idle(1);
      check_bit("rx_full_o", 1'b1, rx_full_o);
      for (int i = 0; i < 4; i++)
         write_beat(TCDM_ADD_WIDTH'(8'hd0 + i * 4), i == 3, 2'd0);
      for (int i = 0; i < 4; i++)
         read_beat(TCDM_ADD_WIDTH'(8'hd0 + i * 4), i == 3, 2'd0);
      idle(2);
   endtask

   initial
   begin
      arst_n_i      = 1'b0;
      rx_push_i     = 1'b0;
      rx_dat_i      = '0;
      rx_strb_i     = '0;
      rx_beat_req_i = 1'b0;
      rx_beat_eop_i = 1'b0;
      rx_beat_sid_i = '0;
      rx_beat_add_i = '0;
      tx_beat_req_i = 1'b0;
      tx_beat_eop_i = 1'b0;
      tx_beat_sid_i = '0;
      tx_beat_add_i = '0;
      tx_ready_i    = 1'b1;
      lfsr_q        = 32'd39;
      last_rx       = 1'b0;
      rd_pend       = 1'b0;
      rx_synch_cnt  = 0;
      tx_synch_cnt  = 0;
      for (int i = 0; i < TCDM_WORDS; i++)
         model_mem[i] = '0;
      repeat (2) @(posedge clk_i);
      @(negedge clk_i);
      arst_n_i = 1'b1;
      test_full_word();
      test_strobe_merge();
      test_synch();
      test_shared_port();
      test_back_pressure();
      $display("Result: PASSED");
      $finish;
   end

endmodule

/* dma_tcdm_top.f */
design/dma_tcdm_pkg.sv
design/rx_data_fifo.sv
design/tcdm_rx_if.sv
design/tcdm_tx_if.sv
design/tcdm_arbiter.sv
design/tcdm_bank.sv
design/dma_tcdm_top.sv
bench/tb_dma_tcdm_top.sv
